/* Makefile */
TOOL      = verilator
FLAGS     = --binary --assert
TOP       = tb_rv_core
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
CASES     = tb/program_cases.txt

BIN     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "No errors" $(LOG)
	! grep -q "Errors found" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e         alu_op,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic                    alu_src_imm,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    zero
);

    logic [rv_pkg::XLEN-1:0]         b;
    logic [$clog2(rv_pkg::XLEN)-1:0] shamt;
    logic                            lt_signed;
    logic                            lt_unsigned;

    // second operand is rs2 or the immediate
    assign b     = alu_src_imm ? imm : rs2_data;
    assign shamt = b[$clog2(rv_pkg::XLEN)-1:0];

    assign lt_signed   = $signed(rs1_data) < $signed(b);
    assign lt_unsigned = rs1_data < b;

    always_comb begin
        case (alu_op)
            rv_pkg::op_sub:  result = rs1_data - b;
            rv_pkg::op_sll:  result = rs1_data << shamt;
            rv_pkg::op_slt:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_pkg::op_sltu: result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::op_xor:  result = rs1_data ^ b;
            rv_pkg::op_srl:  result = rs1_data >> shamt;
            rv_pkg::op_sra:  result = $signed(rs1_data) >>> shamt;
            rv_pkg::op_or:   result = rs1_data | b;
            rv_pkg::op_and:  result = rs1_data & b;
            default:         result = rs1_data + b;
        endcase
    end

    // used by beq and bne after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/control_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
    input  logic                    Clock,
    input  logic                    Reset_L,
    input  rv_pkg::instr_kind_e     kind,
    input  rv_pkg::branch_cond_e    branch_cond,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic                    zero,
    input  logic                    dtack,
    output logic                    latch_instr,
    output logic                    fetch,
    output logic                    reg_write,
    output rv_pkg::wb_sel_e         wb_sel,
    output logic                    alu_src_imm,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    as_l,
    output logic                    we_l,
    output logic                    halted
);

    rv_pkg::state_e          state;
    rv_pkg::pc_sel_e         pc_sel;
    logic [rv_pkg::XLEN-1:0] jump_target;
    logic                    branch_taken;

    // slt and sltu leave exactly one or zero in the result
    always_comb begin
        case (branch_cond)
            rv_pkg::br_eq:                branch_taken = zero;
            rv_pkg::br_ne:                branch_taken = !zero;
            rv_pkg::br_lt, rv_pkg::br_ltu: branch_taken = (alu_result == 32'h1);
            rv_pkg::br_ge, rv_pkg::br_geu: branch_taken = (alu_result == '0);
            default:                      branch_taken = 1'b0;
        endcase
    end

    assign alu_src_imm = kind inside {rv_pkg::kind_alu_imm, rv_pkg::kind_load,
                                      rv_pkg::kind_store, rv_pkg::kind_jalr};

    // pc stays on the bus until the instruction is latched
    assign fetch       = (state == rv_pkg::st_fetch_wait) || (state == rv_pkg::st_latch);
    assign latch_instr = (state == rv_pkg::st_latch);
    assign halted      = (state == rv_pkg::st_halted);

    always_comb begin
        reg_write = 1'b0;
        wb_sel    = rv_pkg::wb_alu;
        case (state)
            rv_pkg::st_write_back: reg_write = 1'b1;
            rv_pkg::st_upper_imm_1: begin
                reg_write = 1'b1;
                wb_sel    = rv_pkg::wb_imm;
            end
            rv_pkg::st_jump_link_1, rv_pkg::st_jump_reg_2: begin
                reg_write = 1'b1;
                wb_sel    = rv_pkg::wb_link;
            end
            // load data is written on the edge that sees dtack
            rv_pkg::st_mem_read_2: begin
                reg_write = dtack;
                wb_sel    = rv_pkg::wb_load;
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state  <= rv_pkg::st_fetch_wait;
            pc     <= rv_pkg::RESET_PC;
            pc_sel <= rv_pkg::pc_plus_step;
            as_l   <= 1'b1;
            we_l   <= 1'b1;
        end else begin
            case (state)
                rv_pkg::st_fetch_wait: state <= rv_pkg::st_latch;
                rv_pkg::st_latch:      state <= rv_pkg::st_execute;
                rv_pkg::st_execute: begin
                    pc_sel <= rv_pkg::pc_plus_step;
                    case (kind)
                        rv_pkg::kind_alu_reg,
                        rv_pkg::kind_alu_imm:   state <= rv_pkg::st_write_back;
                        rv_pkg::kind_load:      state <= rv_pkg::st_mem_read_1;
                        rv_pkg::kind_store:     state <= rv_pkg::st_mem_write_1;
                        rv_pkg::kind_branch:    state <= rv_pkg::st_branch_resolve;
                        rv_pkg::kind_jal:       state <= rv_pkg::st_jump_link_1;
                        rv_pkg::kind_jalr:      state <= rv_pkg::st_jump_reg_1;
                        rv_pkg::kind_upper_imm: state <= rv_pkg::st_upper_imm_1;
                        rv_pkg::kind_halt:      state <= rv_pkg::st_halted;
                        // unknown opcodes fall through to the next word
                        default:                state <= rv_pkg::st_complete;
                    endcase
                end
                rv_pkg::st_write_back,
                rv_pkg::st_upper_imm_1: state <= rv_pkg::st_complete;
                rv_pkg::st_mem_read_1: begin
                    as_l  <= 1'b0;
                    state <= rv_pkg::st_mem_read_2;
                end
                rv_pkg::st_mem_read_2: begin
                    if (dtack) begin
                        as_l  <= 1'b1;
                        state <= rv_pkg::st_complete;
                    end
                end
                rv_pkg::st_mem_write_1: begin
                    as_l  <= 1'b0;
                    we_l  <= 1'b0;
                    state <= rv_pkg::st_mem_write_2;
                end
                rv_pkg::st_mem_write_2: begin
                    if (dtack) begin
                        as_l  <= 1'b1;
                        we_l  <= 1'b1;
                        state <= rv_pkg::st_complete;
                    end
                end
                rv_pkg::st_branch_resolve: begin
                    if (branch_taken) begin
                        pc_sel <= rv_pkg::pc_plus_imm;
                    end
                    state <= rv_pkg::st_complete;
                end
                rv_pkg::st_jump_link_1: begin
                    pc_sel <= rv_pkg::pc_plus_imm;
                    state  <= rv_pkg::st_complete;
                end
                rv_pkg::st_jump_reg_1: begin
                    pc_sel <= rv_pkg::pc_alu;
                    state  <= rv_pkg::st_jump_reg_2;
                end
                rv_pkg::st_jump_reg_2: state <= rv_pkg::st_complete;
                rv_pkg::st_complete: begin
                    case (pc_sel)
                        rv_pkg::pc_plus_imm: pc <= pc + imm;
                        rv_pkg::pc_alu:      pc <= jump_target;
                        default:             pc <= pc + rv_pkg::PC_STEP;
                    endcase
                    state <= rv_pkg::st_fetch_wait;
                end
                // halted holds until reset
                rv_pkg::st_halted: state <= rv_pkg::st_halted;
                default: state <= rv_pkg::st_fetch_wait;
            endcase
        end
    end

    // jalr target is taken before the link write, so rd may equal rs1
    always_ff @(posedge Clock) begin
        if (state == rv_pkg::st_jump_reg_1) begin
            jump_target <= {alu_result[rv_pkg::XLEN-1:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic                              Clock,
    input  logic                              Reset_L,
    input  logic [rv_pkg::XLEN-1:0]           instruction,
    input  logic                              latch_instr,
    input  logic [rv_pkg::XLEN-1:0]           pc,
    output rv_pkg::instr_kind_e               kind,
    output rv_pkg::alu_op_e                   alu_op,
    output rv_pkg::branch_cond_e              branch_cond,
    output rv_pkg::mem_width_e                mem_width,
    output logic [rv_pkg::REG_ADDR_W-1:0]     rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]     rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0]     rd,
    output logic [rv_pkg::XLEN-1:0]           imm
);

    logic [rv_pkg::XLEN-1:0] instr_q;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    funct7_b5;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm_u;

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            instr_q <= rv_pkg::NOP_INSTR;
        end else if (latch_instr) begin
            instr_q <= instruction;
        end
    end

    assign opcode    = instr_q[6:0];
    assign funct3    = instr_q[14:12];
    assign funct7_b5 = instr_q[30];
    assign rs1       = instr_q[19:15];
    assign rs2       = instr_q[24:20];
    assign rd        = instr_q[11:7];

    assign mem_width   = rv_pkg::mem_width_e'(funct3);
    assign branch_cond = rv_pkg::branch_cond_e'(funct3);

    // sign-extended immediates with bit 0 of B and J always zero
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};
    assign imm_u = {instr_q[31:12], 12'h000};

    always_comb begin
        kind   = rv_pkg::kind_illegal;
        alu_op = rv_pkg::op_add;
        imm    = imm_i;
        case (opcode)
            7'b0110011: begin
                kind   = rv_pkg::kind_alu_reg;
                alu_op = rv_pkg::alu_op_e'({funct7_b5, funct3});
            end
            7'b0010011: begin
                kind = rv_pkg::kind_alu_imm;
                // only the shifts look at funct7
                if (funct3[1:0] == 2'b01) begin
                    alu_op = rv_pkg::alu_op_e'({funct7_b5, funct3});
                end else begin
                    alu_op = rv_pkg::alu_op_e'({1'b0, funct3});
                end
            end
            7'b0000011: kind = rv_pkg::kind_load;
            7'b0100011: begin
                kind = rv_pkg::kind_store;
                imm  = imm_s;
            end
            7'b1100011: begin
                kind = rv_pkg::kind_branch;
                imm  = imm_b;
                if (!funct3[2]) begin
                    alu_op = rv_pkg::op_sub;
                end else if (!funct3[1]) begin
                    alu_op = rv_pkg::op_slt;
                end else begin
                    alu_op = rv_pkg::op_sltu;
                end
            end
            7'b1101111: begin
                kind = rv_pkg::kind_jal;
                imm  = imm_j;
            end
            7'b1100111: kind = rv_pkg::kind_jalr;
            // lui
            7'b0110111: begin
                kind = rv_pkg::kind_upper_imm;
                imm  = imm_u;
            end
            // auipc
            7'b0010111: begin
                kind = rv_pkg::kind_upper_imm;
                imm  = imm_u + pc;
            end
            7'b0000000: kind = rv_pkg::kind_halt;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/load_store_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
    input  logic                    fetch,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  rv_pkg::mem_width_e      mem_width,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] data_in,
    output logic [rv_pkg::XLEN-1:0] address,
    output logic [3:0]              byte_enable,
    output logic [rv_pkg::XLEN-1:0] data_out,
    output logic [rv_pkg::XLEN-1:0] load_data
);

    logic [1:0]  offset;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign address = fetch ? pc : alu_result;
    assign offset  = address[1:0];

    // misaligned half and word accesses enable no lanes
    always_comb begin
        byte_enable = 4'b0000;
        case (mem_width)
            rv_pkg::mw_byte: byte_enable = 4'b0001 << offset;
            rv_pkg::mw_half: begin
                if (offset == 2'b00) begin
                    byte_enable = 4'b0011;
                end else if (offset == 2'b10) begin
                    byte_enable = 4'b1100;
                end
            end
            rv_pkg::mw_word: begin
                if (offset == 2'b00) begin
                    byte_enable = 4'b1111;
                end
            end
            default: ;
        endcase
    end

    // store data moves up to the enabled lanes
    always_comb begin
        case (byte_enable)
            4'b0010:          data_out = rs2_data << 8;
            4'b0100, 4'b1100: data_out = rs2_data << 16;
            4'b1000:          data_out = rs2_data << 24;
            4'b0000:          data_out = '0;
            default:          data_out = rs2_data;
        endcase
    end

    assign lane_byte = data_in[{offset, 3'b000} +: 8];
    assign lane_half = offset[1] ? data_in[31:16] : data_in[15:0];

    always_comb begin
        load_data = '0;
        case (mem_width)
            rv_pkg::mw_byte:   load_data = {{24{lane_byte[7]}}, lane_byte};
            rv_pkg::mw_byte_u: load_data = {24'h000000, lane_byte};
            rv_pkg::mw_half: begin
                if (!offset[0]) begin
                    load_data = {{16{lane_half[15]}}, lane_half};
                end
            end
            rv_pkg::mw_half_u: begin
                if (!offset[0]) begin
                    load_data = {16'h0000, lane_half};
                end
            end
            rv_pkg::mw_word: begin
                if (offset == 2'b00) begin
                    load_data = data_in;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_bank (
    input  logic                          Clock,
    input  logic                          Reset_L,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  logic                          reg_write,
    input  rv_pkg::wb_sel_e               wb_sel,
    input  logic [rv_pkg::XLEN-1:0]       alu_result,
    input  logic [rv_pkg::XLEN-1:0]       load_data,
    input  logic [rv_pkg::XLEN-1:0]       imm,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:(2**rv_pkg::REG_ADDR_W)-1];
    logic [rv_pkg::XLEN-1:0] wb_data;

    always_comb begin
        case (wb_sel)
            rv_pkg::wb_load: wb_data = load_data;
            rv_pkg::wb_link: wb_data = pc + rv_pkg::PC_STEP;
            rv_pkg::wb_imm:  wb_data = imm;
            default:         wb_data = alu_result;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int i = 1; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (rd != '0)) begin
            regs[rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic                    Clock,
    input  logic                    Reset_L,
    input  logic                    dtack,
    input  logic [rv_pkg::XLEN-1:0] instruction,
    input  logic [rv_pkg::XLEN-1:0] data_in,
    output logic                    as_l,
    output logic                    we_l,
    output logic [3:0]              byte_enable,
    output logic [rv_pkg::XLEN-1:0] data_out,
    output logic [rv_pkg::XLEN-1:0] address,
    output logic                    halted
);

    rv_pkg::instr_kind_e           kind;
    rv_pkg::alu_op_e               alu_op;
    rv_pkg::branch_cond_e          branch_cond;
    rv_pkg::mem_width_e            mem_width;
    rv_pkg::wb_sel_e               wb_sel;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [rv_pkg::XLEN-1:0]       pc;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       alu_result;
    logic [rv_pkg::XLEN-1:0]       load_data;
    logic                          zero;
    logic                          latch_instr;
    logic                          fetch;
    logic                          reg_write;
    logic                          alu_src_imm;

    instr_decode u_decode (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .instruction (instruction),
        .latch_instr (latch_instr),
        .pc          (pc),
        .kind        (kind),
        .alu_op      (alu_op),
        .branch_cond (branch_cond),
        .mem_width   (mem_width),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm)
    );

    reg_bank u_regs (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .reg_write  (reg_write),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .load_data  (load_data),
        .imm        (imm),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    alu u_alu (
        .alu_op      (alu_op),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_src_imm (alu_src_imm),
        .result      (alu_result),
        .zero        (zero)
    );

    load_store_unit u_lsu (
        .fetch       (fetch),
        .pc          (pc),
        .alu_result  (alu_result),
        .mem_width   (mem_width),
        .rs2_data    (rs2_data),
        .data_in     (data_in),
        .address     (address),
        .byte_enable (byte_enable),
        .data_out    (data_out),
        .load_data   (load_data)
    );

    control_fsm u_ctrl (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .kind        (kind),
        .branch_cond (branch_cond),
        .imm         (imm),
        .alu_result  (alu_result),
        .zero        (zero),
        .dtack       (dtack),
        .latch_instr (latch_instr),
        .fetch       (fetch),
        .reg_write   (reg_write),
        .wb_sel      (wb_sel),
        .alu_src_imm (alu_src_imm),
        .pc          (pc),
        .as_l        (as_l),
        .we_l        (we_l),
        .halted      (halted)
    );

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;
    localparam logic [XLEN-1:0] PC_STEP = 32'h0000_0004;

    typedef enum logic [3:0] {
        kind_alu_reg,
        kind_alu_imm,
        kind_load,
        kind_store,
        kind_branch,
        kind_jal,
        kind_jalr,
        kind_upper_imm,
        kind_halt,
        kind_illegal
    } instr_kind_e;

    // funct7[5] joined with funct3
    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_sll  = 4'b0001,
        op_slt  = 4'b0010,
        op_sltu = 4'b0011,
        op_xor  = 4'b0100,
        op_srl  = 4'b0101,
        op_or   = 4'b0110,
        op_and  = 4'b0111,
        op_sub  = 4'b1000,
        op_sra  = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        br_eq  = 3'h0,
        br_ne  = 3'h1,
        br_lt  = 3'h4,
        br_ge  = 3'h5,
        br_ltu = 3'h6,
        br_geu = 3'h7
    } branch_cond_e;

    typedef enum logic [2:0] {
        mw_byte   = 3'h0,
        mw_half   = 3'h1,
        mw_word   = 3'h2,
        mw_byte_u = 3'h4,
        mw_half_u = 3'h5
    } mem_width_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link,
        wb_imm
    } wb_sel_e;

    typedef enum logic [1:0] {
        pc_plus_step,
        pc_plus_imm,
        pc_alu
    } pc_sel_e;

    typedef enum logic [3:0] {
        st_fetch_wait,
        st_latch,
        st_execute,
        st_write_back,
        st_mem_read_1,
        st_mem_read_2,
        st_mem_write_1,
        st_mem_write_2,
        st_branch_resolve,
        st_jump_link_1,
        st_jump_reg_1,
        st_jump_reg_2,
        st_upper_imm_1,
        st_complete,
        st_halted
    } state_e;

endpackage

`default_nettype wire

/* sim.f */
rtl/rv_pkg.sv
rtl/instr_decode.sv
rtl/reg_bank.sv
rtl/alu.sv
rtl/load_store_unit.sv
rtl/control_fsm.sv
rtl/rv_core.sv
tb/rv_core_assertions.sv
tb/tb_rv_core.sv

/* tb/program_cases.txt */
// @000 program words, @080 initial data words, @100 store records
// record columns: address, byte enable, data on enabled lanes; ffffffff ends the list
@000
FFB00093 00300113 002081B3 40110233 4020D2B3 0020D333 0020A3B3 0020B433
0F014493 00811513 00A4E5B3 07C0F613 02302023 02402023 02502023 02602023
02702023 02802023 02902023 02A02023 02B02023 02C02023 00300683 00204703
00201783 00005803 00100883 00402903 00101983 02D02023 02E02023 02F02023
03002023 03102023 03202023 03302023 032000A3 03201123 032001A3 03201023
032010A3 ABCDEA37 00001A97 03402023 03502023 00210463 04202023 00208463
04202223 00211463 04202423 00209463 04202623 0020C463 04202823 00114463
04202A23 0020D463 04202C23 00115463 04202E23 0020E463 06202023 00116463
06202223 0020F463 06202423 00117463 06202623 00800B6F 06202823 00CB0BE7
06202823 03602023 03702023 00000000
@080
80F17E02 12345678
@100
00000020 0000000F FFFFFFFE  00000020 0000000F 00000008  00000020 0000000F FFFFFFFF
00000020 0000000F 1FFFFFFF  00000020 0000000F 00000001  00000020 0000000F 00000000
00000020 0000000F 000000F3  00000020 0000000F 00000300  00000020 0000000F 000003F3
00000020 0000000F 00000078  00000020 0000000F FFFFFF80  00000020 0000000F 000000F1
00000020 0000000F FFFF80F1  00000020 0000000F 00007E02  00000020 0000000F 0000007E
00000020 0000000F 12345678  00000020 0000000F 00000000  00000021 00000002 00007800
00000022 0000000C 56780000  00000023 00000008 78000000  00000020 00000003 00005678
00000021 00000000 00000000  00000020 0000000F ABCDE000  00000020 0000000F 000010A8
00000044 0000000F 00000003  00000048 0000000F 00000003  00000054 0000000F 00000003
00000058 0000000F 00000003  00000060 0000000F 00000003  0000006C 0000000F 00000003
00000020 0000000F 00000118  00000020 0000000F 00000120
FFFFFFFF

/* tb/rv_core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_assertions (
    input logic Clock,
    input logic Reset_L,
    input logic as_l,
    input logic we_l,
    input logic halted
);

    // a write is always part of an addressed cycle
    assert property (@(posedge Clock) disable iff (!Reset_L) !we_l |-> !as_l)
        else $error("we_l low while as_l high");

    assert property (@(posedge Clock) !Reset_L |-> as_l)
        else $error("as_l low during reset");

    assert property (@(posedge Clock) disable iff (!Reset_L) halted |=> halted)
        else $error("halted fell without reset");

    // no bus access once the core has stopped
    assert property (@(posedge Clock) disable iff (!Reset_L) halted |=> as_l)
        else $error("as_l low after halted");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .Clock   (Clock),
    .Reset_L (Reset_L),
    .as_l    (as_l),
    .we_l    (we_l),
    .halted  (halted)
);

`default_nettype wire

/* tb/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    localparam int CASE_WORDS       = 512;
    localparam int PROG_WORDS       = 128;
    localparam int DATA_BASE        = 'h80;
    localparam int DATA_WORDS       = 64;
    localparam int REC_BASE         = 'h100;
    localparam int CYCLES_PER_INSTR = 10;
    localparam int INSTR_PER_WORD   = 10;

    logic        Clock;
    logic        Reset_L;
    logic        dtack;
    logic [31:0] instruction;
    logic [31:0] data_in;
    logic        as_l;
    logic        we_l;
    logic [3:0]  byte_enable;
    logic [31:0] data_out;
    logic [31:0] address;
    logic        halted;

    // program, initial data and store records in one flat image
    logic [31:0] case_mem [0:CASE_WORDS-1];
    logic [31:0] dmem [0:DATA_WORDS-1];
    int          rec_idx;
    int          prog_len;
    integer      seed;
    integer      rnd;
    int          wait_left;
    logic        busy;

    rv_core dut0 (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .dtack       (dtack),
        .instruction (instruction),
        .data_in     (data_in),
        .as_l        (as_l),
        .we_l        (we_l),
        .byte_enable (byte_enable),
        .data_out    (data_out),
        .address     (address),
        .halted      (halted)
    );

    initial Clock = 1'b0;
    always #4 Clock = ~Clock;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s actual %h expected %h",
                               $time, name, actual, expected));
        end
    endtask

    // compares the bus against the next expected store record
    task automatic check_store();
        logic [31:0] mask;
        mask = {{8{byte_enable[3]}}, {8{byte_enable[2]}},
                {8{byte_enable[1]}}, {8{byte_enable[0]}}};
        if (case_mem[rec_idx] === 32'hFFFF_FFFF) begin
            fail_run($sformatf("unexpected store to %h after the last expected store", address));
        end
        check_value("address", address, case_mem[rec_idx]);
        check_value("byte_enable", {28'h0, byte_enable}, case_mem[rec_idx+1]);
        check_value("data_out", data_out & mask, case_mem[rec_idx+2] & mask);
        rec_idx = rec_idx + 3;
    endtask

    task automatic write_lanes();
        for (int i = 0; i < 4; i++) begin
            if (byte_enable[i]) begin
                dmem[address[7:2]][i*8 +: 8] = data_out[i*8 +: 8];
            end
        end
    endtask

    // instruction and data memory driven on the falling edge
    always @(negedge Clock) begin
        instruction = case_mem[{2'b00, address[8:2]}];
        if (!Reset_L || as_l) begin
            dtack = 1'b0;
            busy  = 1'b0;
        end else if (!dtack) begin
            if (!busy) begin
                busy      = 1'b1;
                rnd       = $random(seed);
                wait_left = int'(rnd[1:0]);
            end
            if (wait_left == 0) begin
                data_in = dmem[address[7:2]];
                if (!we_l) begin
                    check_store();
                    write_lanes();
                end
                dtack = 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        Reset_L     = 1'b1;
        dtack       = 1'b0;
        instruction = '0;
        data_in     = '0;
        seed        = 32'ha54a;
        busy        = 1'b0;
        wait_left   = 0;
        rec_idx     = REC_BASE;
        prog_len    = 0;
        for (int i = 0; i < CASE_WORDS; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("tb/program_cases.txt", case_mem);
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = case_mem[DATA_BASE+i];
        end
        // length up to and including the halt word
        while (prog_len < PROG_WORDS - 1 && case_mem[prog_len] != '0) begin
            prog_len = prog_len + 1;
        end
        prog_len = prog_len + 1;

        #1 Reset_L = 1'b0;
        repeat (3) @(posedge Clock);
        check_value("as_l", {31'h0, as_l}, 32'h1);
        check_value("we_l", {31'h0, we_l}, 32'h1);
        check_value("halted", {31'h0, halted}, 32'h0);
        @(negedge Clock);
        Reset_L = 1'b1;

        wait (halted === 1'b1);
        repeat (4) @(negedge Clock);
        if (case_mem[rec_idx] !== 32'hFFFF_FFFF) begin
            fail_run($sformatf("core halted before the expected store to %h",
                               case_mem[rec_idx]));
        end else begin
            $display("No errors");
            $finish;
        end
    end

    initial begin
        wait (prog_len > 0);
        repeat (prog_len * INSTR_PER_WORD * CYCLES_PER_INSTR) @(posedge Clock);
        fail_run("timeout: the core did not reach the halt instruction");
    end

endmodule

`default_nettype wire
